/* common/tlb_cfg.svh */
// tlb geometry, address split and bit positions of the entry fields
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// ----------------------------------------
// geometry
// ----------------------------------------

// fully associative, one slot per entry
`define TLB_ENTRIES      32
`define TLB_IDX_W        5

// 4 KB pages on a 32-bit address
`define TLB_PAGE_W       20
`define TLB_OFFSET_W     12

// ----------------------------------------
// entry layout, lowest field first
// ----------------------------------------

// virtual page tag
`define TLB_BIT_VPAGE_LO 0
// physical page
`define TLB_BIT_PPAGE_LO 20
`define TLB_BIT_VALID    40
// combined pde/pte permissions
`define TLB_BIT_RW       41
`define TLB_BIT_SU       42
// top bit of an entry
`define TLB_BIT_DIRTY    43

`endif

/* common/tlb_addr_pkg.sv */
// linear, physical, page number and page offset address types
`default_nettype none

`include "tlb_cfg.svh"

package tlb_addr_pkg;

    // ----------------------------------------
    // full addresses
    // ----------------------------------------

    // linear address as seen by the core
    typedef logic [`TLB_PAGE_W+`TLB_OFFSET_W-1:0] linear_addr_t;

    // physical address after translation
    typedef logic [`TLB_PAGE_W+`TLB_OFFSET_W-1:0] phys_addr_t;

    // ----------------------------------------
    // address fields
    // ----------------------------------------

    // upper part used as the entry tag
    typedef logic [`TLB_PAGE_W-1:0] page_num_t;

    // passes through translation unchanged
    typedef logic [`TLB_OFFSET_W-1:0] page_offset_t;

endpackage

`default_nettype wire

/* common/tlb_entry_pkg.sv */
// entry, slot index, slot mask and pseudo-lru tree types
`default_nettype none

`include "tlb_cfg.svh"

package tlb_entry_pkg;

    // ----------------------------------------
    // stored entry
    // ----------------------------------------

    // vpage, ppage, valid, rw, su, dirty from bit 0 up
    typedef logic [`TLB_BIT_DIRTY:0] tlb_entry_t;

    // ----------------------------------------
    // slot selection
    // ----------------------------------------

    // binary slot number
    typedef logic [`TLB_IDX_W-1:0] entry_idx_t;

    // one bit per slot with bit 0 for slot 0
    typedef logic [`TLB_ENTRIES-1:0] entry_mask_t;

    // ----------------------------------------
    // replacement state
    // ----------------------------------------

    // heap order with children 2n+1 and 2n+2 under node n
    // nodes 15..30 sit right above the slots
    // a node at 1 points the victim to its lower-indexed half
    typedef logic [`TLB_ENTRIES-2:0] plru_tree_t;

endpackage

`default_nettype wire

/* tlb/tlb_entry_array.sv */
// tlb entry registers with write, single-page flush, stale flush and flush-all
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tlb_entry_array (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire tlb_entry_pkg::entry_mask_t  write_mask,
    input  wire tlb_addr_pkg::linear_addr_t  write_linear,
    input  wire tlb_addr_pkg::phys_addr_t    write_physical,
    input  wire logic                   write_combined_rw,
    input  wire logic                   write_combined_su,
    input  wire logic                   rw,
    input  wire logic                   flush_single_do,
    input  wire tlb_addr_pkg::linear_addr_t  flush_single_linear,
    input  wire logic                   flush_all_do,
    input  wire tlb_entry_pkg::entry_mask_t  stale_mask,
    output tlb_entry_pkg::tlb_entry_t   entries [`TLB_ENTRIES],
    output tlb_entry_pkg::entry_mask_t  valid_vec
);

    tlb_entry_pkg::tlb_entry_t  new_entry;
    tlb_addr_pkg::page_num_t    flush_page;

    assign flush_page = flush_single_linear[`TLB_OFFSET_W +: `TLB_PAGE_W];

    // ----------------------------------------
    // entry being written this cycle
    // ----------------------------------------

    always_comb begin
        new_entry = '0;
        new_entry[`TLB_BIT_VPAGE_LO +: `TLB_PAGE_W] =
            write_linear[`TLB_OFFSET_W +: `TLB_PAGE_W];
        new_entry[`TLB_BIT_PPAGE_LO +: `TLB_PAGE_W] =
            write_physical[`TLB_OFFSET_W +: `TLB_PAGE_W];
        new_entry[`TLB_BIT_VALID] = 1'b1;
        new_entry[`TLB_BIT_RW]    = write_combined_rw;
        new_entry[`TLB_BIT_SU]    = write_combined_su;
        // walker refills for a write with dirty already set
        new_entry[`TLB_BIT_DIRTY] = rw;
    end

    // ----------------------------------------
    // slots
    // ----------------------------------------

    for (genvar i = 0; i < `TLB_ENTRIES; i++) begin : g_entry
        logic flush_hit;

        assign flush_hit = flush_single_do &&
            (entries[i][`TLB_BIT_VPAGE_LO +: `TLB_PAGE_W] == flush_page);

        // any kind of flush wins over a write to the same slot
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                entries[i] <= '0;
            end else if (flush_all_do || flush_hit || stale_mask[i]) begin
                entries[i] <= '0;
            end else if (write_mask[i]) begin
                entries[i] <= new_entry;
            end
        end

        assign valid_vec[i] = entries[i][`TLB_BIT_VALID];
    end

    // replacement must never pick two slots at once
    a_write_single_slot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(write_mask)
    ) else $error("tlb write selects more than one slot");

endmodule

`default_nettype wire

/* tlb/tlb_lookup.sv */
// tag compare, hit select, dirty check and translation outputs
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tlb_lookup (
    input  wire logic                   translate_do,
    input  wire logic                   rw,
    input  wire tlb_addr_pkg::linear_addr_t  translate_linear,
    input  wire tlb_entry_pkg::tlb_entry_t   entries [`TLB_ENTRIES],
    output tlb_entry_pkg::entry_mask_t  hit_mask,
    output tlb_entry_pkg::entry_mask_t  stale_mask,
    output logic                        translate_valid,
    output logic                        translate_combined_rw,
    output logic                        translate_combined_su,
    output tlb_addr_pkg::phys_addr_t    translate_physical
);

    tlb_addr_pkg::page_num_t    page;
    tlb_addr_pkg::page_offset_t offset;
    tlb_entry_pkg::tlb_entry_t  selected;
    logic                       hit_any;
    logic                       clean_write;

    assign page   = translate_linear[`TLB_OFFSET_W +: `TLB_PAGE_W];
    assign offset = translate_linear[`TLB_OFFSET_W-1:0];

    // ----------------------------------------
    // compare against all valid slots
    // ----------------------------------------

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            hit_mask[i] = translate_do && entries[i][`TLB_BIT_VALID] &&
                (entries[i][`TLB_BIT_VPAGE_LO +: `TLB_PAGE_W] == page);
        end
    end

    // and-or mux, at most one slot matches
    always_comb begin
        selected = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (hit_mask[i]) begin
                selected = selected | entries[i];
            end
        end
    end

    assign hit_any = |hit_mask;

    // ----------------------------------------
    // dirty check
    // ----------------------------------------

    // write to a clean page goes back to the walker to set dirty
    assign clean_write = hit_any && rw && !selected[`TLB_BIT_DIRTY];
    assign stale_mask  = clean_write ? hit_mask : '0;

    assign translate_valid = hit_any && (!rw || selected[`TLB_BIT_DIRTY]);

    assign translate_physical = translate_valid ?
        {selected[`TLB_BIT_PPAGE_LO +: `TLB_PAGE_W], offset} : translate_linear;

    assign translate_combined_rw = selected[`TLB_BIT_RW];
    assign translate_combined_su = selected[`TLB_BIT_SU];

    // no duplicate tags may exist in the entry array
    always_comb begin
        a_hit_onehot: assert ($onehot0(hit_mask))
            else $error("tlb page matches more than one slot");
    end

endmodule

`default_nettype wire

/* tlb/tlb_replace.sv */
// free-slot finder, pseudo-lru tree and choice of the slot to write
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tlb_replace (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire logic                   write_do,
    input  wire logic                   flush_all_do,
    input  wire tlb_entry_pkg::entry_mask_t  valid_vec,
    input  wire tlb_entry_pkg::entry_mask_t  hit_mask,
    output tlb_entry_pkg::entry_mask_t  write_mask
);

    tlb_entry_pkg::plru_tree_t   tree;
    tlb_entry_pkg::plru_tree_t   tree_next;
    tlb_entry_pkg::entry_idx_t   free_idx;
    tlb_entry_pkg::entry_idx_t   victim_idx;
    tlb_entry_pkg::entry_idx_t   write_idx;
    tlb_entry_pkg::entry_idx_t   touch_idx;
    tlb_entry_pkg::entry_mask_t  touch_mask;
    logic                        full;
    logic                        touch_any;

    // ----------------------------------------
    // slot choice
    // ----------------------------------------

    assign full = &valid_vec;

    // lowest free slot, counting down so slot 0 wins
    always_comb begin
        free_idx = '0;
        for (int i = `TLB_ENTRIES-1; i >= 0; i--) begin
            if (!valid_vec[i]) begin
                free_idx = tlb_entry_pkg::entry_idx_t'(i);
            end
        end
    end

    // root to leaf, one index bit per level, msb first
    always_comb begin
        int   node;
        logic go_upper;
        node       = 0;
        victim_idx = '0;
        for (int l = 0; l < `TLB_IDX_W; l++) begin
            go_upper = ~tree[node];
            victim_idx[`TLB_IDX_W-1-l] = go_upper;
            node = 2*node + (go_upper ? 2 : 1);
        end
    end

    assign write_idx  = full ? victim_idx : free_idx;
    assign write_mask = write_do ?
        (tlb_entry_pkg::entry_mask_t'(1) << write_idx) : '0;

    // ----------------------------------------
    // tree update
    // ----------------------------------------

    assign touch_mask = write_mask | hit_mask;
    assign touch_any  = |touch_mask;

    always_comb begin
        touch_idx = '0;
        for (int i = `TLB_ENTRIES-1; i >= 0; i--) begin
            if (touch_mask[i]) begin
                touch_idx = tlb_entry_pkg::entry_idx_t'(i);
            end
        end
    end

    // each node on the path points to the other half
    // so the node value equals the slot's index bit
    always_comb begin
        int   node;
        logic upper;
        tree_next = tree;
        node      = 0;
        for (int l = 0; l < `TLB_IDX_W; l++) begin
            upper = touch_idx[`TLB_IDX_W-1-l];
            tree_next[node] = upper;
            node = 2*node + (upper ? 2 : 1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tree <= '0;
        end else if (flush_all_do) begin
            tree <= '0;
        end else if (touch_any) begin
            tree <= tree_next;
        end
    end

    a_write_mask_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !write_do |-> (write_mask == '0)
    ) else $error("tlb write slot selected without a write");

endmodule

`default_nettype wire

/* src/tlb_top.sv */
// tlb top level with entry storage, lookup and replacement
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tlb_top (
    input  wire                         clk,
    input  wire                         rst_n,
    // translate request, rw 1 for a write access
    input  wire logic                   translate_do,
    input  wire tlb_addr_pkg::linear_addr_t  translate_linear,
    input  wire logic                   rw,
    // refill from the page walker
    input  wire logic                   write_do,
    input  wire tlb_addr_pkg::linear_addr_t  write_linear,
    input  wire tlb_addr_pkg::phys_addr_t    write_physical,
    input  wire logic                   write_combined_rw,
    input  wire logic                   write_combined_su,
    // invalidation
    input  wire logic                   flush_single_do,
    input  wire tlb_addr_pkg::linear_addr_t  flush_single_linear,
    input  wire logic                   flush_all_do,
    // translation result, same cycle
    output logic                        translate_valid,
    output tlb_addr_pkg::phys_addr_t    translate_physical,
    output logic                        translate_combined_rw,
    output logic                        translate_combined_su
);

    tlb_entry_pkg::tlb_entry_t   entries [`TLB_ENTRIES];
    tlb_entry_pkg::entry_mask_t  valid_vec;
    tlb_entry_pkg::entry_mask_t  hit_mask;
    tlb_entry_pkg::entry_mask_t  stale_mask;
    tlb_entry_pkg::entry_mask_t  write_mask;

    // ----------------------------------------
    // storage
    // ----------------------------------------

    tlb_entry_array u_entry_array (
        .clk                 (clk),
        .rst_n               (rst_n),
        .write_mask          (write_mask),
        .write_linear        (write_linear),
        .write_physical      (write_physical),
        .write_combined_rw   (write_combined_rw),
        .write_combined_su   (write_combined_su),
        .rw                  (rw),
        .flush_single_do     (flush_single_do),
        .flush_single_linear (flush_single_linear),
        .flush_all_do        (flush_all_do),
        .stale_mask          (stale_mask),
        .entries             (entries),
        .valid_vec           (valid_vec)
    );

    // ----------------------------------------
    // compare and select
    // ----------------------------------------

    tlb_lookup u_lookup (
        .translate_do          (translate_do),
        .rw                    (rw),
        .translate_linear      (translate_linear),
        .entries               (entries),
        .hit_mask              (hit_mask),
        .stale_mask            (stale_mask),
        .translate_valid       (translate_valid),
        .translate_combined_rw (translate_combined_rw),
        .translate_combined_su (translate_combined_su),
        .translate_physical    (translate_physical)
    );

    // ----------------------------------------
    // replacement
    // ----------------------------------------

    tlb_replace u_replace (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_do     (write_do),
        .flush_all_do (flush_all_do),
        .valid_vec    (valid_vec),
        .hit_mask     (hit_mask),
        .write_mask   (write_mask)
    );

endmodule

`default_nettype wire

/* sim/tlb_tb.sv */
// directed tlb testbench with reference model, compare tasks, tests and timeout
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tlb_tb;

    // longest run is well under a thousand cycles
    localparam int MAX_CYCLES = 4000;

    logic                        clk;
    logic                        rst_n;
    logic                        translate_do;
    tlb_addr_pkg::linear_addr_t  translate_linear;
    logic                        rw;
    logic                        write_do;
    tlb_addr_pkg::linear_addr_t  write_linear;
    tlb_addr_pkg::phys_addr_t    write_physical;
    logic                        write_combined_rw;
    logic                        write_combined_su;
    logic                        flush_single_do;
    tlb_addr_pkg::linear_addr_t  flush_single_linear;
    logic                        flush_all_do;
    logic                        translate_valid;
    tlb_addr_pkg::phys_addr_t    translate_physical;
    logic                        translate_combined_rw;
    logic                        translate_combined_su;

    // reference model, one row per slot
    logic                        m_valid [`TLB_ENTRIES];
    tlb_addr_pkg::page_num_t     m_vpage [`TLB_ENTRIES];
    tlb_addr_pkg::page_num_t     m_ppage [`TLB_ENTRIES];
    logic                        m_rw    [`TLB_ENTRIES];
    logic                        m_su    [`TLB_ENTRIES];
    logic                        m_dirty [`TLB_ENTRIES];
    tlb_entry_pkg::plru_tree_t   m_tree;

    tlb_addr_pkg::page_num_t     pages [$];
    logic [31:0]                 lcg_state = 32'd33991;
    int                          cycle_count = 0;
    int                          check_count = 0;
    int                          error_count = 0;

    tlb_top u_tlb_top (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .translate_do          (translate_do),
        .translate_linear      (translate_linear),
        .rw                    (rw),
        .write_do              (write_do),
        .write_linear          (write_linear),
        .write_physical        (write_physical),
        .write_combined_rw     (write_combined_rw),
        .write_combined_su     (write_combined_su),
        .flush_single_do       (flush_single_do),
        .flush_single_linear   (flush_single_linear),
        .flush_all_do          (flush_all_do),
        .translate_valid       (translate_valid),
        .translate_physical    (translate_physical),
        .translate_combined_rw (translate_combined_rw),
        .translate_combined_su (translate_combined_su)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic void model_clear();
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        m_tree = '0;
    endfunction

    function automatic int model_find(tlb_addr_pkg::page_num_t page);
        int slot;
        slot = -1;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (m_valid[i] && m_vpage[i] == page) begin
                slot = i;
            end
        end
        return slot;
    endfunction

    // lowest free slot, else walk down the tree
    function automatic int model_pick_slot();
        int slot;
        int node;
        slot = -1;
        for (int i = `TLB_ENTRIES-1; i >= 0; i--) begin
            if (!m_valid[i]) begin
                slot = i;
            end
        end
        if (slot < 0) begin
            node = 0;
            while (node < `TLB_ENTRIES-1) begin
                node = m_tree[node] ? 2*node + 1 : 2*node + 2;
            end
            slot = node - (`TLB_ENTRIES-1);
        end
        return slot;
    endfunction

    // climb from the slot, each parent points to the sibling half
    function automatic void model_touch(int slot);
        int node;
        int parent;
        node = slot + `TLB_ENTRIES - 1;
        while (node > 0) begin
            parent = (node - 1) / 2;
            m_tree[parent] = (node == 2*parent + 1) ? 1'b0 : 1'b1;
            node = parent;
        end
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic check_phys(string name, tlb_addr_pkg::phys_addr_t actual,
                              tlb_addr_pkg::phys_addr_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(string name, logic actual, logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // ----------------------------------------
    // bus operations
    // ----------------------------------------

    task automatic write_entry(tlb_addr_pkg::page_num_t vpage, tlb_addr_pkg::page_num_t ppage,
                               logic crw, logic csu, logic dirty);
        int slot;
        @(posedge clk);
        write_do          <= 1'b1;
        write_linear      <= {vpage, 12'h5a5};
        write_physical    <= {ppage, 12'h3c3};
        write_combined_rw <= crw;
        write_combined_su <= csu;
        rw                <= dirty;
        @(posedge clk);
        write_do <= 1'b0;
        rw       <= 1'b0;
        slot = model_pick_slot();
        m_valid[slot] = 1'b1;
        m_vpage[slot] = vpage;
        m_ppage[slot] = ppage;
        m_rw[slot]    = crw;
        m_su[slot]    = csu;
        m_dirty[slot] = dirty;
        model_touch(slot);
    endtask

    task automatic translate_check(tlb_addr_pkg::linear_addr_t linear, logic wr);
        int                        slot;
        logic                      exp_valid;
        tlb_addr_pkg::phys_addr_t  exp_phys;
        slot = model_find(linear[`TLB_OFFSET_W +: `TLB_PAGE_W]);
        exp_valid = 1'b0;
        exp_phys  = linear;
        if (slot >= 0 && (!wr || m_dirty[slot])) begin
            exp_valid = 1'b1;
            exp_phys  = {m_ppage[slot], linear[`TLB_OFFSET_W-1:0]};
        end
        @(posedge clk);
        translate_do     <= 1'b1;
        translate_linear <= linear;
        rw               <= wr;
        // outputs are combinational, settled by mid cycle
        @(negedge clk);
        check_bit("translate_valid", translate_valid, exp_valid);
        check_phys("translate_physical", translate_physical, exp_phys);
        if (exp_valid) begin
            check_bit("translate_combined_rw", translate_combined_rw, m_rw[slot]);
            check_bit("translate_combined_su", translate_combined_su, m_su[slot]);
        end
        @(posedge clk);
        translate_do <= 1'b0;
        rw           <= 1'b0;
        if (slot >= 0) begin
            model_touch(slot);
            if (wr && !m_dirty[slot]) begin
                m_valid[slot] = 1'b0;
            end
        end
    endtask

    task automatic flush_page(tlb_addr_pkg::page_num_t page);
        @(posedge clk);
        flush_single_do     <= 1'b1;
        flush_single_linear <= {page, 12'h777};
        @(posedge clk);
        flush_single_do <= 1'b0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (m_vpage[i] == page) begin
                m_valid[i] = 1'b0;
            end
        end
    endtask

    task automatic flush_everything();
        @(posedge clk);
        flush_all_do <= 1'b1;
        @(posedge clk);
        flush_all_do <= 1'b0;
        model_clear();
    endtask

    task automatic report_test(string name, int errors_before);
        $display("test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    task automatic test_reset_state();
        int errors_before;
        errors_before = error_count;
        translate_check(32'h0000_0000, 1'b0);
        translate_check(32'h1234_5678, 1'b0);
        translate_check(32'hffff_f001, 1'b1);
        report_test("reset_state", errors_before);
    endtask

    task automatic test_hit_permissions();
        int errors_before;
        errors_before = error_count;
        write_entry(20'h00012, 20'h80034, 1'b1, 1'b0, 1'b1);
        write_entry(20'h00013, 20'h80099, 1'b0, 1'b1, 1'b1);
        translate_check(32'h0001_2abc, 1'b0);
        translate_check(32'h0001_2def, 1'b1);
        translate_check(32'h0001_3010, 1'b0);
        translate_check(32'h0001_3fff, 1'b1);
        report_test("hit_permissions", errors_before);
    endtask

    task automatic test_clean_write();
        int errors_before;
        errors_before = error_count;
        write_entry(20'h00200, 20'h90200, 1'b1, 1'b1, 1'b0);
        translate_check(32'h0020_0123, 1'b0);
        // write to a clean page misses and drops the entry
        translate_check(32'h0020_0456, 1'b1);
        translate_check(32'h0020_0789, 1'b0);
        report_test("clean_write", errors_before);
    endtask

    task automatic test_flush();
        int errors_before;
        errors_before = error_count;
        write_entry(20'h00300, 20'ha0300, 1'b0, 1'b0, 1'b1);
        write_entry(20'h00301, 20'ha0301, 1'b1, 1'b1, 1'b1);
        flush_page(20'h00300);
        translate_check(32'h0030_0004, 1'b0);
        translate_check(32'h0030_1008, 1'b0);
        flush_everything();
        translate_check(32'h0030_1008, 1'b0);
        translate_check(32'h0001_2abc, 1'b0);
        report_test("flush", errors_before);
    endtask

    task automatic test_replacement();
        int                       errors_before;
        logic [31:0]              rnd;
        tlb_addr_pkg::page_num_t  page;
        bit                       seen;
        errors_before = error_count;
        flush_everything();
        pages.delete();
        while (pages.size() < 40) begin
            rnd  = lcg_next();
            page = rnd[31:12];
            seen = 1'b0;
            foreach (pages[j]) begin
                if (pages[j] == page) begin
                    seen = 1'b1;
                end
            end
            if (!seen) begin
                pages.push_back(page);
            end
        end
        for (int i = 0; i < 32; i++) begin
            rnd = lcg_next();
            write_entry(pages[i], ~pages[i], rnd[4], rnd[9], rnd[14]);
        end
        // touched pages should survive the next round of refills
        for (int i = 0; i < 32; i += 5) begin
            translate_check({pages[i], 12'h010}, 1'b0);
        end
        for (int i = 32; i < 40; i++) begin
            write_entry(pages[i], ~pages[i], 1'b1, 1'b0, 1'b1);
        end
        for (int i = 0; i < 40; i++) begin
            translate_check({pages[i], 12'h0f0}, 1'b0);
        end
        report_test("replacement", errors_before);
    endtask

    initial begin
        rst_n               = 1'b0;
        translate_do        = 1'b0;
        translate_linear    = '0;
        rw                  = 1'b0;
        write_do            = 1'b0;
        write_linear        = '0;
        write_physical      = '0;
        write_combined_rw   = 1'b0;
        write_combined_su   = 1'b0;
        flush_single_do     = 1'b0;
        flush_single_linear = '0;
        flush_all_do        = 1'b0;
        model_clear();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_hit_permissions();
        test_clean_write();
        test_flush();
        test_replacement();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/tlb_addr_pkg.sv
common/tlb_entry_pkg.sv
tlb/tlb_entry_array.sv
tlb/tlb_lookup.sv
tlb/tlb_replace.sv
src/tlb_top.sv
sim/tlb_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module tlb_tb \
		-Mdir obj_dir -o tlb_sim

run: build
	./obj_dir/tlb_sim | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module tlb_tb

clean:
	rm -rf obj_dir $(LOG)
